//--- design/rtcMapPkg.sv
package rtcMapPkg;

	////////////////////////////////
	// Field map widths
	////////////////////////////////
	localparam int AddrWidth = 3;
	localparam int DataWidth = 8;
	localparam int FieldCount = 7;

	// RTC register addresses, seconds first
	localparam logic [AddrWidth-1:0] SecondsAddr = 3'd1;
	localparam logic [AddrWidth-1:0] MinutesAddr = 3'd2;
	localparam logic [AddrWidth-1:0] HoursAddr = 3'd3;
	localparam logic [AddrWidth-1:0] WeekdayAddr = 3'd4;
	localparam logic [AddrWidth-1:0] DayAddr = 3'd5;
	localparam logic [AddrWidth-1:0] MonthAddr = 3'd6;
	localparam logic [AddrWidth-1:0] YearAddr = 3'd7;

	// Bounds of the scanned range
	localparam logic [AddrWidth-1:0] FirstField = SecondsAddr;
	localparam logic [AddrWidth-1:0] LastField = AddrWidth'(FirstField + FieldCount - 1);

	// Modulus of each field, counting from zero
	function automatic logic [DataWidth-1:0] fieldLimit(input logic [AddrWidth-1:0] addr);
		case (addr)
			SecondsAddr: return 8'd60;
			MinutesAddr: return 8'd60;
			HoursAddr: return 8'd24;
			WeekdayAddr: return 8'd7;
			DayAddr: return 8'd31;
			MonthAddr: return 8'd12;
			YearAddr: return 8'd100;
			// Address 0 holds no field
			default: return 8'd1;
		endcase
	endfunction

endpackage

//--- design/menuPkg.sv
package menuPkg;

	////////////////////////////////
	// Main menu states
	////////////////////////////////
	typedef enum logic [2:0] {
		Scan,
		ScanWait,
		Settle,
		Poll,
		WriteWait
	} menuState_t;

	////////////////////////////////
	// Cursor commands from a poll
	////////////////////////////////
	typedef enum logic [1:0] {
		None,
		Left,
		Right,
		Home
	} cursorMove_t;

endpackage

//--- design/menuFsm.sv
`timescale 1ns/10ps

module menuFsm (
	input logic CLK,
	input logic RST,
	input logic btnUp,
	input logic btnDown,
	input logic btnLeft,
	input logic btnRight,
	input logic btnCenter,
	input logic accessDone,
	input logic scanLast,
	input logic timerDone,
	output logic accessStart,
	output logic accessWrite,
	output logic scanClear,
	output logic scanStep,
	output logic captureEn,
	output logic timerStart,
	output logic stepUp,
	output logic refreshed,
	output menuPkg::cursorMove_t cursorMove
);

	menuPkg::menuState_t state;
	menuPkg::menuState_t nextState;
	// High from a start until its done
	logic accessPending;

	////////////////////////////////
	// State and access tracking
	////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state <= menuPkg::Scan;
			accessPending <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (accessStart)
				accessPending <= 1'b1;
			else if (accessDone)
				accessPending <= 1'b0;
		end
	end

	////////////////////////////////
	// Next state and outputs
	////////////////////////////////
	always_comb
	begin
		nextState = state;
		accessStart = 1'b0;
		accessWrite = 1'b0;
		scanClear = 1'b0;
		scanStep = 1'b0;
		captureEn = 1'b0;
		timerStart = 1'b0;
		stepUp = 1'b0;
		refreshed = 1'b0;
		cursorMove = menuPkg::None;
		case (state)
			// One read per field
			menuPkg::Scan:
			begin
				accessStart = 1'b1;
				nextState = menuPkg::ScanWait;
			end
			menuPkg::ScanWait:
			begin
				if (accessDone)
				begin
					captureEn = 1'b1;
					if (scanLast)
					begin
						// Whole map read, start the settle wait
						scanClear = 1'b1;
						refreshed = 1'b1;
						timerStart = 1'b1;
						nextState = menuPkg::Settle;
					end
					else
					begin
						scanStep = 1'b1;
						nextState = menuPkg::Scan;
					end
				end
			end
			menuPkg::Settle:
			begin
				if (timerDone)
					nextState = menuPkg::Poll;
			end
			// Priority Up, Down, Left, Right, Center
			menuPkg::Poll:
			begin
				nextState = menuPkg::Scan;
				if (btnUp || btnDown)
				begin
					accessStart = 1'b1;
					accessWrite = 1'b1;
					stepUp = btnUp;
					nextState = menuPkg::WriteWait;
				end
				else if (btnLeft)
					cursorMove = menuPkg::Left;
				else if (btnRight)
					cursorMove = menuPkg::Right;
				else if (btnCenter)
					cursorMove = menuPkg::Home;
			end
			// Rescan once the write lands
			menuPkg::WriteWait:
			begin
				if (accessDone)
					nextState = menuPkg::Scan;
			end
			default:
				nextState = menuPkg::Scan;
		endcase
	end

	// Single access in flight on the RTC bus
	assert property (@(posedge CLK) disable iff (RST) accessStart |-> !accessPending)
		else $error("accessStart while an access is outstanding");

endmodule

//--- design/scanCounter.sv
`timescale 1ns/10ps

module scanCounter (
	input logic CLK,
	input logic RST,
	input logic scanClear,
	input logic scanStep,
	output logic [rtcMapPkg::AddrWidth-1:0] scanAddr,
	output logic scanLast
);

	////////////////////////////////
	// Scan address register
	////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			scanAddr <= rtcMapPkg::FirstField;
		else if (scanClear)
			scanAddr <= rtcMapPkg::FirstField;
		else if (scanStep)
			scanAddr <= scanAddr + rtcMapPkg::AddrWidth'(1);
	end

	// Year is the final field
	assign scanLast = (scanAddr == rtcMapPkg::LastField);

	// Never leaves the field map
	assert property (@(posedge CLK) disable iff (RST)
		scanAddr >= rtcMapPkg::FirstField && scanAddr <= rtcMapPkg::LastField)
		else $error("scanAddr outside the field map");

endmodule

//--- design/waitTimer.sv
`timescale 1ns/10ps

module waitTimer #(
	parameter int WaitCycles = 100
) (
	input logic CLK,
	input logic RST,
	input logic timerStart,
	output logic timerDone
);

	localparam int CountWidth = $clog2(WaitCycles + 1);

	// Zero means idle
	logic [CountWidth-1:0] count;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			count <= '0;
		else if (timerStart)
			count <= CountWidth'(WaitCycles);
		else if (count != '0)
			count <= count - CountWidth'(1);
	end

	// Last counted cycle, WaitCycles after the start
	assign timerDone = (count == CountWidth'(1));

endmodule

//--- design/editCursor.sv
`timescale 1ns/10ps

module editCursor (
	input logic CLK,
	input logic RST,
	input menuPkg::cursorMove_t cursorMove,
	output logic [rtcMapPkg::AddrWidth-1:0] cursorAddr
);

	////////////////////////////////
	// Edit pointer
	////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			cursorAddr <= rtcMapPkg::FirstField;
		else
		begin
			case (cursorMove)
				// Left counts up, wraps after year
				menuPkg::Left:
					cursorAddr <= (cursorAddr == rtcMapPkg::LastField) ?
						rtcMapPkg::FirstField : cursorAddr + rtcMapPkg::AddrWidth'(1);
				// Right counts down, wraps below seconds
				menuPkg::Right:
					cursorAddr <= (cursorAddr == rtcMapPkg::FirstField) ?
						rtcMapPkg::LastField : cursorAddr - rtcMapPkg::AddrWidth'(1);
				menuPkg::Home:
					cursorAddr <= rtcMapPkg::FirstField;
				default:
					cursorAddr <= cursorAddr;
			endcase
		end
	end

	// Address 0 is not a field
	assert property (@(posedge CLK) disable iff (RST) cursorAddr != '0)
		else $error("cursorAddr reached 0");

endmodule

//--- design/fieldStore.sv
`timescale 1ns/10ps

module fieldStore (
	input logic CLK,
	input logic RST,
	input logic captureEn,
	input logic [rtcMapPkg::AddrWidth-1:0] captureAddr,
	input logic [rtcMapPkg::AddrWidth-1:0] cursorAddr,
	input logic [rtcMapPkg::AddrWidth-1:0] viewAddr,
	input logic [rtcMapPkg::DataWidth-1:0] captureData,
	input logic stepUp,
	output logic [rtcMapPkg::DataWidth-1:0] nextValue,
	output logic [rtcMapPkg::DataWidth-1:0] viewData
);

	// Local copy of the RTC fields
	logic [rtcMapPkg::DataWidth-1:0] fields [rtcMapPkg::FirstField:rtcMapPkg::LastField];
	logic [rtcMapPkg::DataWidth-1:0] cursorValue;
	logic [rtcMapPkg::DataWidth-1:0] cursorLimit;

	////////////////////////////////
	// Capture from scan reads
	////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			for (int i = rtcMapPkg::FirstField; i <= rtcMapPkg::LastField; i++)
				fields[i] <= '0;
		end
		else if (captureEn)
			fields[captureAddr] <= captureData;
	end

	////////////////////////////////
	// Wrapped step of cursor field
	////////////////////////////////
	assign cursorValue = fields[cursorAddr];
	assign cursorLimit = rtcMapPkg::fieldLimit(cursorAddr);

	always_comb
	begin
		if (stepUp)
			// Out of range values also fold back to zero
			nextValue = (cursorValue >= cursorLimit - 8'd1) ? '0 : cursorValue + 8'd1;
		else if (cursorValue == '0 || cursorValue >= cursorLimit)
			nextValue = cursorLimit - 8'd1;
		else
			nextValue = cursorValue - 8'd1;
	end

	// Panel readout, zero outside the map
	assign viewData = (viewAddr >= rtcMapPkg::FirstField && viewAddr <= rtcMapPkg::LastField) ?
		fields[viewAddr] : '0;

endmodule

//--- design/busMaster.sv
`timescale 1ns/10ps

module busMaster (
	input logic CLK,
	input logic RST,
	input logic accessStart,
	input logic accessWrite,
	input logic [rtcMapPkg::AddrWidth-1:0] accessAddr,
	input logic [rtcMapPkg::DataWidth-1:0] accessWdata,
	output logic accessDone,
	output logic [rtcMapPkg::DataWidth-1:0] accessRdata,
	output logic busReq,
	output logic busWrite,
	output logic [rtcMapPkg::AddrWidth-1:0] busAddr,
	output logic [rtcMapPkg::DataWidth-1:0] busWdata,
	input logic busDone,
	input logic [rtcMapPkg::DataWidth-1:0] busRdata
);

	////////////////////////////////
	// Request level and done
	////////////////////////////////
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			busReq <= 1'b0;
			busWrite <= 1'b0;
			accessDone <= 1'b0;
		end
		else
		begin
			// Done follows busDone by one cycle
			accessDone <= busReq && busDone;
			if (accessStart)
			begin
				busReq <= 1'b1;
				busWrite <= accessWrite;
			end
			else if (busDone)
				busReq <= 1'b0;
		end
	end

	// Address and data held for the whole access
	always_ff @(posedge CLK)
	begin
		if (accessStart)
		begin
			busAddr <= accessAddr;
			busWdata <= accessWdata;
		end
		if (busReq && busDone)
			accessRdata <= busRdata;
	end

	assert property (@(posedge CLK) disable iff (RST)
		busReq && !busDone |=> $stable(busAddr) && $stable(busWdata) && $stable(busWrite))
		else $error("RTC bus payload changed during a request");

endmodule

//--- design/rtcMenu.sv
`timescale 1ns/10ps

module rtcMenu #(
	parameter int WaitCycles = 100
) (
	input logic CLK,
	input logic RST,
	input logic up,
	input logic down,
	input logic left,
	input logic right,
	input logic center,
	output logic [rtcMapPkg::AddrWidth-1:0] cursor,
	output logic refreshed,
	input logic [rtcMapPkg::AddrWidth-1:0] viewAddr,
	output logic [rtcMapPkg::DataWidth-1:0] viewData,
	output logic busReq,
	output logic busWrite,
	output logic [rtcMapPkg::AddrWidth-1:0] busAddr,
	output logic [rtcMapPkg::DataWidth-1:0] busWdata,
	input logic busDone,
	input logic [rtcMapPkg::DataWidth-1:0] busRdata
);

	logic accessStart;
	logic accessWrite;
	logic accessDone;
	logic [rtcMapPkg::AddrWidth-1:0] accessAddr;
	logic [rtcMapPkg::DataWidth-1:0] accessRdata;
	logic scanClear;
	logic scanStep;
	logic scanLast;
	logic [rtcMapPkg::AddrWidth-1:0] scanAddr;
	logic captureEn;
	logic timerStart;
	logic timerDone;
	logic stepUp;
	logic [rtcMapPkg::DataWidth-1:0] nextValue;
	menuPkg::cursorMove_t cursorMove;
	logic [rtcMapPkg::AddrWidth-1:0] cursorAddr;

	////////////////////////////////
	// Control
	////////////////////////////////
	menuFsm fsm (.CLK, .RST, .btnUp(up), .btnDown(down), .btnLeft(left),
		.btnRight(right), .btnCenter(center), .accessDone, .scanLast, .timerDone,
		.accessStart, .accessWrite, .scanClear, .scanStep, .captureEn, .timerStart,
		.stepUp, .refreshed, .cursorMove);

	scanCounter scanCnt (.CLK, .RST, .scanClear, .scanStep, .scanAddr, .scanLast);

	waitTimer #(.WaitCycles(WaitCycles)) settleTimer (.CLK, .RST, .timerStart, .timerDone);

	editCursor cursorReg (.CLK, .RST, .cursorMove, .cursorAddr);

	////////////////////////////////
	// Data path and RTC bus
	////////////////////////////////
	fieldStore store (.CLK, .RST, .captureEn, .captureAddr(scanAddr), .cursorAddr, .viewAddr,
		.captureData(accessRdata), .stepUp, .nextValue, .viewData);

	// Writes go to the edited field, reads follow the scan
	assign accessAddr = accessWrite ? cursorAddr : scanAddr;

	busMaster bus (.CLK, .RST, .accessStart, .accessWrite, .accessAddr,
		.accessWdata(nextValue), .accessDone, .accessRdata, .busReq, .busWrite, .busAddr,
		.busWdata, .busDone, .busRdata);

	assign cursor = cursorAddr;

endmodule

//--- bench/rtcMenuTb.sv
`timescale 1ns/10ps

module rtcMenuTb;

	localparam int WaitCycles = 20;
	// Scan cycle, request, up to four wait cycles, done handoff
	localparam int ReadWorst = 8;
	// Polls in the button sequence below
	localparam int TotalPolls = 39;
	localparam int LoopWorst = 7 * ReadWorst + WaitCycles + 2 + ReadWorst;
	localparam int TimeoutCycles = (TotalPolls + 1) * LoopWorst + 20;

	logic CLK = 1'b0;
	logic RST = 1'b1;
	logic up = 1'b0;
	logic down = 1'b0;
	logic left = 1'b0;
	logic right = 1'b0;
	logic center = 1'b0;
	logic [rtcMapPkg::AddrWidth-1:0] viewAddr = 3'd1;
	logic busDone = 1'b0;
	logic [rtcMapPkg::DataWidth-1:0] busRdata = 8'd0;
	logic [rtcMapPkg::AddrWidth-1:0] cursor;
	logic refreshed;
	logic [rtcMapPkg::DataWidth-1:0] viewData;
	logic busReq;
	logic busWrite;
	logic [rtcMapPkg::AddrWidth-1:0] busAddr;
	logic [rtcMapPkg::DataWidth-1:0] busWdata;

	// RTC model state
	logic [rtcMapPkg::DataWidth-1:0] rtcFields [1:7];
	int moduli [1:7] = '{60, 60, 24, 7, 31, 12, 100};
	int seed = 43;
	int delayLeft = 0;
	logic serving = 1'b0;

	// Reference bookkeeping
	int errors = 0;
	int cycleCount = 0;
	int nextRead;
	int sinceRefresh;
	logic inSettle;
	logic polledUp;
	logic polledDown;
	logic [rtcMapPkg::AddrWidth-1:0] expCursor;
	logic [rtcMapPkg::DataWidth-1:0] expWrite;

	rtcMenu #(.WaitCycles(WaitCycles)) DUT (.CLK, .RST, .up, .down, .left, .right, .center,
		.cursor, .refreshed, .viewAddr, .viewData, .busReq, .busWrite, .busAddr, .busWdata,
		.busDone, .busRdata);

	initial
	begin
		forever
			#4 CLK = ~CLK;
	end

	function automatic logic [7:0] steppedValue(input int modulus, input logic [7:0] value,
		input logic upward);
		if (upward)
			return 8'((int'(value) + 1) % modulus);
		return 8'((int'(value) + modulus - 1) % modulus);
	endfunction

	task automatic countFailure(input string msg);
		errors++;
		$display("%s", msg);
	endtask

	//////////////////////////////
	// RTC bus model
	//////////////////////////////
	always @(posedge CLK)
	begin
		if (RST)
		begin
			busDone <= 1'b0;
			serving = 1'b0;
			for (int a = 1; a <= 7; a++)
				rtcFields[a] <= 8'($unsigned($random(seed)) % rtcMapPkg::fieldLimit(3'(a)));
		end
		else if (busDone)
		begin
			busDone <= 1'b0;
			serving = 1'b0;
		end
		else if (busReq)
		begin
			// New request, pick 1 to 4 cycles
			if (!serving)
			begin
				serving = 1'b1;
				delayLeft = 1 + ($unsigned($random(seed)) % 4);
			end
			delayLeft = delayLeft - 1;
			if (delayLeft == 0)
			begin
				busDone <= 1'b1;
				if (busWrite)
					rtcFields[busAddr] <= busWdata;
				else
					busRdata <= rtcFields[busAddr];
			end
		end
	end

	// Panel readout walks all fields
	always @(posedge CLK)
		viewAddr <= (viewAddr == 3'd7) ? 3'd1 : viewAddr + 3'd1;

	//////////////////////////////
	// Expected scan and poll state
	//////////////////////////////
	always @(posedge CLK)
	begin
		if (RST)
		begin
			nextRead <= 1;
			sinceRefresh <= 0;
			expCursor <= 3'd1;
			polledUp <= 1'b0;
			polledDown <= 1'b0;
		end
		else
		begin
			if (refreshed)
				nextRead <= 1;
			else if (busReq && busDone && !busWrite)
				nextRead <= nextRead + 1;
			if (refreshed)
				sinceRefresh <= 1;
			else if (sinceRefresh != 0)
				sinceRefresh <= sinceRefresh + 1;
			// Poll cycle, priority Up Down Left Right Center
			if (sinceRefresh == WaitCycles + 1)
			begin
				polledUp <= up;
				polledDown <= down;
				if (!up && !down)
				begin
					if (left)
						expCursor <= (expCursor == 3'd7) ? 3'd1 : expCursor + 3'd1;
					else if (right)
						expCursor <= (expCursor == 3'd1) ? 3'd7 : expCursor - 3'd1;
					else if (center)
						expCursor <= 3'd1;
				end
			end
		end
	end

	assign inSettle = (sinceRefresh >= 1) && (sinceRefresh <= WaitCycles);
	assign expWrite = steppedValue(moduli[cursor], rtcFields[cursor], polledUp);

	//////////////////////////////
	// Checks
	//////////////////////////////
	assert property (@(posedge CLK) disable iff (RST)
		$rose(busReq) && !busWrite |-> int'(busAddr) == nextRead)
		else countFailure($sformatf("Error scanOrder: expected %0d actual %0d",
			$sampled(nextRead), $sampled(busAddr)));

	assert property (@(posedge CLK) disable iff (RST) refreshed |-> nextRead == 8)
		else countFailure($sformatf("Error scanCount: expected %0d actual %0d",
			7, $sampled(nextRead) - 1));

	assert property (@(posedge CLK) disable iff (RST) busReq && !busDone |=> busReq)
		else countFailure("busReq dropped before busDone");

	assert property (@(posedge CLK) disable iff (RST) busReq && busDone |=> !busReq)
		else countFailure("busReq still high after busDone");

	assert property (@(posedge CLK) disable iff (RST)
		inSettle |-> viewData == rtcFields[viewAddr])
		else countFailure($sformatf("Error storeContents: expected %0d actual %0d",
			$sampled(rtcFields[viewAddr]), $sampled(viewData)));

	assert property (@(posedge CLK) disable iff (RST) inSettle |-> !busReq)
		else countFailure("bus request during the settle time");

	assert property (@(posedge CLK) disable iff (RST)
		$rose(busReq) && busWrite |-> busAddr == cursor)
		else countFailure($sformatf("Error writeAddr: expected %0d actual %0d",
			$sampled(cursor), $sampled(busAddr)));

	assert property (@(posedge CLK) disable iff (RST)
		$rose(busReq) && busWrite |-> busWdata == expWrite)
		else countFailure($sformatf("Error writeValue: expected %0d actual %0d",
			$sampled(expWrite), $sampled(busWdata)));

	// Writes only from Up or Down, right after the poll
	assert property (@(posedge CLK) disable iff (RST)
		$rose(busReq) && busWrite |-> (polledUp || polledDown) && sinceRefresh == WaitCycles + 2)
		else countFailure("write issued without Up or Down in the poll");

	assert property (@(posedge CLK) disable iff (RST)
		sinceRefresh == WaitCycles + 2 && (polledUp || polledDown) |-> busReq && busWrite)
		else countFailure("no write after a poll with Up or Down");

	assert property (@(posedge CLK) disable iff (RST) cursor == expCursor)
		else countFailure($sformatf("Error cursorMove: expected %0d actual %0d",
			$sampled(expCursor), $sampled(cursor)));

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic waitRefresh();
		@(negedge CLK);
		while (!refreshed)
			@(negedge CLK);
	endtask

	// Buttons as {up, down, left, right, center}
	task automatic holdButtons(input logic [4:0] pattern, input int polls);
		@(posedge CLK);
		{up, down, left, right, center} <= pattern;
		repeat (polls)
			waitRefresh();
	endtask

	initial
	begin
		repeat (2)
			@(posedge CLK);
		RST <= 1'b0;
		waitRefresh();
		holdButtons(5'b00000, 1);
		holdButtons(5'b10000, 3);
		// Cursor to weekday, then wrap both ways
		holdButtons(5'b00100, 3);
		holdButtons(5'b10000, 8);
		holdButtons(5'b01000, 8);
		// Left beats Right, wraps past year
		holdButtons(5'b00110, 4);
		holdButtons(5'b00010, 2);
		holdButtons(5'b01000, 3);
		holdButtons(5'b10100, 1);
		holdButtons(5'b00011, 1);
		holdButtons(5'b00001, 1);
		holdButtons(5'b01000, 2);
		holdButtons(5'b11000, 1);
		holdButtons(5'b00000, 1);
		@(posedge CLK);
		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// Run limit
	initial
	begin
		while (cycleCount < TimeoutCycles)
		begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("Timeout after %0d cycles, the button sequence did not finish", cycleCount);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- sim.f
design/rtcMapPkg.sv
design/menuPkg.sv
design/menuFsm.sv
design/scanCounter.sv
design/waitTimer.sv
design/editCursor.sv
design/fieldStore.sv
design/busMaster.sv
design/rtcMenu.sv
bench/rtcMenuTb.sv

//--- run.sh
#!/bin/sh
# Build and run the rtcMenu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module rtcMenuTb -f sim.f

output=$(./obj_dir/VrtcMenuTb)
printf '%s\n' "$output"

# Pass only when the pass message was printed
printf '%s\n' "$output" | grep -q "Finished with no errors"
